// File: hdl/periph_pkg.sv
package periph_pkg;

  // bus shape
  localparam int AddrWidth = 16;
  localparam int DataWidth = 32;

  typedef logic [AddrWidth-1:0] periph_addr_t;
  typedef logic [DataWidth-1:0] periph_data_t;

  // address bits 15:12 select the block
  typedef logic [3:0] region_t;
  localparam region_t RegionPlic = 4'd0;
  localparam region_t RegionUart = 4'd1;
  localparam region_t RegionSpi  = 4'd2;

  // word offset from address bits 5:2
  typedef logic [3:0] reg_offset_t;

  // ------------------------------
  // interrupt controller
  // ------------------------------
  localparam int NumSources = 2;
  localparam int NumTargets = 2;
  localparam int PrioWidth  = 3;

  // id 0 means nothing to claim
  typedef logic [1:0] irq_id_t;
  localparam irq_id_t SrcUart = 2'd1;
  localparam irq_id_t SrcSpi  = 2'd2;

  localparam reg_offset_t OffPrio1   = 4'd1;
  localparam reg_offset_t OffPrio2   = 4'd2;
  localparam reg_offset_t OffPending = 4'd4;
  localparam reg_offset_t OffEnable0 = 4'd5;
  localparam reg_offset_t OffEnable1 = 4'd6;
  localparam reg_offset_t OffThresh0 = 4'd8;
  localparam reg_offset_t OffThresh1 = 4'd9;
  localparam reg_offset_t OffClaim0  = 4'd10;
  localparam reg_offset_t OffClaim1  = 4'd11;

  // ------------------------------
  // uart and spi
  // ------------------------------
  localparam reg_offset_t OffUartData   = 4'd0;
  localparam reg_offset_t OffUartStatus = 4'd1;
  localparam reg_offset_t OffUartDiv    = 4'd2;
  localparam reg_offset_t OffUartIrqEn  = 4'd3;

  localparam int UartDivWidth = 16;
  localparam logic [UartDivWidth-1:0] UartDivReset = 16'd16;
  localparam logic [UartDivWidth-1:0] UartDivMin   = 16'd4;

  localparam reg_offset_t OffSpiData   = 4'd0;
  localparam reg_offset_t OffSpiStatus = 4'd1;
  localparam reg_offset_t OffSpiIrqEn  = 4'd2;

  // clock cycles per spi clock half period
  localparam int SpiHalfPeriod = 4;

endpackage

// File: hdl/plic.sv
`timescale 1ns/1ps

module plic
  import periph_pkg::*;
(
  input  logic                  clk_i,
  input  logic                  reset_i,
  input  logic                  sel_i,
  input  logic                  write_i,
  input  reg_offset_t           offset_i,
  input  periph_data_t          wdata_i,
  input  logic [NumSources-1:0] irq_sources_i,
  output periph_data_t          rdata_o,
  output logic [NumTargets-1:0] irq_o
);

  logic [PrioWidth-1:0]  prio_q     [NumSources];
  logic [NumSources-1:0] enable_q   [NumTargets];
  logic [PrioWidth-1:0]  thresh_q   [NumTargets];
  logic [NumSources-1:0] pending_q;
  logic [NumSources-1:0] in_service_q;
  irq_id_t               best_id    [NumTargets];
  logic [PrioWidth-1:0]  best_prio  [NumTargets];
  logic [NumTargets-1:0] claim_rd;
  logic [NumTargets-1:0] complete_wr;
  logic [NumSources-1:0] claim_mask;
  logic [NumSources-1:0] complete_mask;

  // ------------------------------
  // arbitration per target
  // ------------------------------
  // strict compare so ties stay with the lower id
  always_comb begin
    for (int t = 0; t < NumTargets; t++) begin
      best_id[t]   = '0;
      best_prio[t] = '0;
      for (int s = 0; s < NumSources; s++) begin
        if (pending_q[s] && enable_q[t][s] && (prio_q[s] > best_prio[t])) begin
          best_prio[t] = prio_q[s];
          best_id[t]   = irq_id_t'(s + 1);
        end
      end
      irq_o[t] = best_prio[t] > thresh_q[t];
    end
  end

  // claim on read, complete on write of the same offset
  assign claim_rd[0]    = sel_i && !write_i && (offset_i == OffClaim0);
  assign claim_rd[1]    = sel_i && !write_i && (offset_i == OffClaim1);
  assign complete_wr[0] = sel_i && write_i && (offset_i == OffClaim0);
  assign complete_wr[1] = sel_i && write_i && (offset_i == OffClaim1);

  always_comb begin
    claim_mask    = '0;
    complete_mask = '0;
    for (int t = 0; t < NumTargets; t++) begin
      for (int s = 0; s < NumSources; s++) begin
        if (claim_rd[t] && (best_id[t] == irq_id_t'(s + 1))) begin
          claim_mask[s] = 1'b1;
        end
        if (complete_wr[t] && (wdata_i[$bits(irq_id_t)-1:0] == irq_id_t'(s + 1))) begin
          complete_mask[s] = 1'b1;
        end
      end
    end
  end

  // ------------------------------
  // state and config registers
  // ------------------------------
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      prio_q       <= '{default: '0};
      enable_q     <= '{default: '0};
      thresh_q     <= '{default: '0};
      pending_q    <= '0;
      in_service_q <= '0;
    end else begin
      // level gateway, masked while the source is in service
      pending_q    <= irq_sources_i & ~in_service_q & ~claim_mask;
      in_service_q <= (in_service_q & ~complete_mask) | claim_mask;
      if (sel_i && write_i) begin
        case (offset_i)
          OffPrio1:   prio_q[0]   <= wdata_i[PrioWidth-1:0];
          OffPrio2:   prio_q[1]   <= wdata_i[PrioWidth-1:0];
          OffEnable0: enable_q[0] <= wdata_i[NumSources-1:0];
          OffEnable1: enable_q[1] <= wdata_i[NumSources-1:0];
          OffThresh0: thresh_q[0] <= wdata_i[PrioWidth-1:0];
          OffThresh1: thresh_q[1] <= wdata_i[PrioWidth-1:0];
          default: ;
        endcase
      end
    end
  end

  always_comb begin
    rdata_o = '0;
    case (offset_i)
      OffPrio1:   rdata_o[PrioWidth-1:0]        = prio_q[0];
      OffPrio2:   rdata_o[PrioWidth-1:0]        = prio_q[1];
      OffPending: rdata_o[NumSources-1:0]       = pending_q;
      OffEnable0: rdata_o[NumSources-1:0]       = enable_q[0];
      OffEnable1: rdata_o[NumSources-1:0]       = enable_q[1];
      OffThresh0: rdata_o[PrioWidth-1:0]        = thresh_q[0];
      OffThresh1: rdata_o[PrioWidth-1:0]        = thresh_q[1];
      OffClaim0:  rdata_o[$bits(irq_id_t)-1:0]  = best_id[0];
      OffClaim1:  rdata_o[$bits(irq_id_t)-1:0]  = best_id[1];
      default: ;
    endcase
  end

endmodule

// File: hdl/uart_core.sv
`timescale 1ns/1ps

module uart_core
  import periph_pkg::*;
(
  input  logic         clk_i,
  input  logic         reset_i,
  input  logic         sel_i,
  input  logic         write_i,
  input  reg_offset_t  offset_i,
  input  periph_data_t wdata_i,
  input  logic         rx_i,
  output periph_data_t rdata_o,
  output logic         tx_o,
  output logic         irq_o
);

  logic [UartDivWidth-1:0] div_q;
  logic                    irq_en_q;
  logic                    data_wr;
  logic                    data_rd;
  // transmit side
  logic                    tx_busy_q;
  logic [UartDivWidth-1:0] tx_cnt_q;
  logic [3:0]              tx_bit_q;
  logic [9:0]              tx_shift_q;
  // receive side
  logic                    rx_meta_q;
  logic                    rx_q;
  logic                    rx_prev_q;
  logic                    rx_busy_q;
  logic [UartDivWidth-1:0] rx_cnt_q;
  logic [3:0]              rx_bit_q;
  logic [7:0]              rx_shift_q;
  logic [7:0]              rx_data_q;
  logic                    rx_valid_q;

  assign data_wr = sel_i && write_i && (offset_i == OffUartData);
  assign data_rd = sel_i && !write_i && (offset_i == OffUartData);

  // ------------------------------
  // registers
  // ------------------------------
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      div_q    <= UartDivReset;
      irq_en_q <= 1'b0;
    end else if (sel_i && write_i) begin
      if (offset_i == OffUartDiv) begin
        // too short a bit time breaks mid-bit sampling
        if (wdata_i[UartDivWidth-1:0] < UartDivMin) begin
          div_q <= UartDivMin;
        end else begin
          div_q <= wdata_i[UartDivWidth-1:0];
        end
      end
      if (offset_i == OffUartIrqEn) begin
        irq_en_q <= wdata_i[0];
      end
    end
  end

  // ------------------------------
  // transmitter
  // ------------------------------
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      tx_busy_q <= 1'b0;
      tx_cnt_q  <= '0;
      tx_bit_q  <= '0;
    end else if (!tx_busy_q) begin
      if (data_wr) begin
        tx_busy_q <= 1'b1;
        tx_cnt_q  <= '0;
        tx_bit_q  <= '0;
      end
    end else if (tx_cnt_q == div_q - 1'b1) begin
      tx_cnt_q <= '0;
      if (tx_bit_q == 4'd9) begin
        tx_busy_q <= 1'b0;
      end else begin
        tx_bit_q <= tx_bit_q + 1'b1;
      end
    end else begin
      tx_cnt_q <= tx_cnt_q + 1'b1;
    end
  end

  // stop, data lsb first, start
  always_ff @(posedge clk_i) begin
    if (!tx_busy_q && data_wr) begin
      tx_shift_q <= {1'b1, wdata_i[7:0], 1'b0};
    end else if (tx_busy_q && (tx_cnt_q == div_q - 1'b1)) begin
      tx_shift_q <= {1'b1, tx_shift_q[9:1]};
    end
  end

  assign tx_o = tx_busy_q ? tx_shift_q[0] : 1'b1;

  // ------------------------------
  // receiver
  // ------------------------------
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      rx_meta_q  <= 1'b1;
      rx_q       <= 1'b1;
      rx_prev_q  <= 1'b1;
      rx_busy_q  <= 1'b0;
      rx_cnt_q   <= '0;
      rx_bit_q   <= '0;
      rx_valid_q <= 1'b0;
    end else begin
      rx_meta_q <= rx_i;
      rx_q      <= rx_meta_q;
      rx_prev_q <= rx_q;
      if (data_rd) begin
        rx_valid_q <= 1'b0;
      end
      if (!rx_busy_q) begin
        if (rx_prev_q && !rx_q) begin
          // first sample lands half a bit in
          rx_busy_q <= 1'b1;
          rx_cnt_q  <= (div_q >> 1) - 1'b1;
          rx_bit_q  <= '0;
        end
      end else if (rx_cnt_q == '0) begin
        rx_cnt_q <= div_q - 1'b1;
        rx_bit_q <= rx_bit_q + 1'b1;
        if ((rx_bit_q == 4'd0) && rx_q) begin
          // glitch, not a start bit
          rx_busy_q <= 1'b0;
        end else if (rx_bit_q == 4'd9) begin
          rx_busy_q  <= 1'b0;
          rx_valid_q <= 1'b1;
        end
      end else begin
        rx_cnt_q <= rx_cnt_q - 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (rx_busy_q && (rx_cnt_q == '0)) begin
      if ((rx_bit_q != 4'd0) && (rx_bit_q != 4'd9)) begin
        rx_shift_q <= {rx_q, rx_shift_q[7:1]};
      end
      if (rx_bit_q == 4'd9) begin
        rx_data_q <= rx_shift_q;
      end
    end
  end

  assign irq_o = rx_valid_q && irq_en_q;

  always_comb begin
    rdata_o = '0;
    case (offset_i)
      OffUartData:   rdata_o[7:0] = rx_data_q;
      OffUartStatus: rdata_o[1:0] = {rx_valid_q, tx_busy_q};
      OffUartDiv:    rdata_o[UartDivWidth-1:0] = div_q;
      OffUartIrqEn:  rdata_o[0] = irq_en_q;
      default: ;
    endcase
  end

endmodule

// File: hdl/spi_master.sv
`timescale 1ns/1ps

module spi_master
  import periph_pkg::*;
(
  input  logic         clk_i,
  input  logic         reset_i,
  input  logic         sel_i,
  input  logic         write_i,
  input  reg_offset_t  offset_i,
  input  periph_data_t wdata_i,
  input  logic         spi_miso_i,
  output periph_data_t rdata_o,
  output logic         spi_clk_o,
  output logic         spi_mosi_o,
  output logic         spi_ss_o,
  output logic         irq_o
);

  logic                             busy_q;
  logic                             done_q;
  logic                             irq_en_q;
  logic                             sclk_q;
  logic [$clog2(SpiHalfPeriod)-1:0] hp_cnt_q;
  logic [2:0]                       bit_cnt_q;
  logic [7:0]                       shift_q;
  logic                             miso_q;
  logic                             data_wr;
  logic                             data_rd;
  logic                             hp_end;

  assign data_wr = sel_i && write_i && (offset_i == OffSpiData);
  assign data_rd = sel_i && !write_i && (offset_i == OffSpiData);
  assign hp_end  = busy_q && (int'(hp_cnt_q) == SpiHalfPeriod - 1);

  // ------------------------------
  // transfer control
  // ------------------------------
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      busy_q    <= 1'b0;
      done_q    <= 1'b0;
      irq_en_q  <= 1'b0;
      sclk_q    <= 1'b0;
      hp_cnt_q  <= '0;
      bit_cnt_q <= '0;
    end else begin
      if (data_rd) begin
        done_q <= 1'b0;
      end
      if (sel_i && write_i && (offset_i == OffSpiIrqEn)) begin
        irq_en_q <= wdata_i[0];
      end
      if (!busy_q) begin
        if (data_wr) begin
          busy_q    <= 1'b1;
          hp_cnt_q  <= '0;
          bit_cnt_q <= '0;
        end
      end else if (hp_end) begin
        hp_cnt_q <= '0;
        sclk_q   <= !sclk_q;
        // falling edge closes one bit
        if (sclk_q) begin
          bit_cnt_q <= bit_cnt_q + 1'b1;
          if (bit_cnt_q == 3'd7) begin
            busy_q <= 1'b0;
            done_q <= 1'b1;
          end
        end
      end else begin
        hp_cnt_q <= hp_cnt_q + 1'b1;
      end
    end
  end

  // mode 0, miso caught on the rise, shifted in on the fall
  always_ff @(posedge clk_i) begin
    if (!busy_q && data_wr) begin
      shift_q <= wdata_i[7:0];
    end else if (hp_end && !sclk_q) begin
      miso_q <= spi_miso_i;
    end else if (hp_end && sclk_q) begin
      shift_q <= {shift_q[6:0], miso_q};
    end
  end

  assign spi_clk_o  = sclk_q;
  assign spi_mosi_o = shift_q[7];
  assign spi_ss_o   = !busy_q;
  assign irq_o      = done_q && irq_en_q;

  always_comb begin
    rdata_o = '0;
    case (offset_i)
      OffSpiData:   rdata_o[7:0] = shift_q;
      OffSpiStatus: rdata_o[1:0] = {done_q, busy_q};
      OffSpiIrqEn:  rdata_o[0]   = irq_en_q;
      default: ;
    endcase
  end

endmodule

// File: hdl/ariane_peripherals.sv
`timescale 1ns/1ps

module ariane_peripherals
  import periph_pkg::*;
(
  input  logic                  clk_i,
  input  logic                  reset_i,
  input  logic                  reg_valid_i,
  input  logic                  reg_write_i,
  input  periph_addr_t          reg_addr_i,
  input  periph_data_t          reg_wdata_i,
  output logic                  reg_rvalid_o,
  output periph_data_t          reg_rdata_o,
  output logic [NumTargets-1:0] irq_o,
  // uart
  input  logic                  rx_i,
  output logic                  tx_o,
  // spi
  output logic                  spi_clk_o,
  output logic                  spi_mosi_o,
  input  logic                  spi_miso_i,
  output logic                  spi_ss_o
);

  region_t      region;
  reg_offset_t  offset;
  logic         plic_sel;
  logic         uart_sel;
  logic         spi_sel;
  periph_data_t plic_rdata;
  periph_data_t uart_rdata;
  periph_data_t spi_rdata;
  periph_data_t rdata_mux;
  logic         uart_irq;
  logic         spi_irq;
  logic         rvalid_q;
  periph_data_t rdata_q;

  // ------------------------------
  // region decode
  // ------------------------------
  assign region = reg_addr_i[15:12];
  assign offset = reg_addr_i[5:2];

  assign plic_sel = reg_valid_i && (region == RegionPlic);
  assign uart_sel = reg_valid_i && (region == RegionUart);
  assign spi_sel  = reg_valid_i && (region == RegionSpi);

  // unused regions read as zero
  always_comb begin
    case (region)
      RegionPlic: rdata_mux = plic_rdata;
      RegionUart: rdata_mux = uart_rdata;
      RegionSpi:  rdata_mux = spi_rdata;
      default:    rdata_mux = '0;
    endcase
  end

  // sampled at the access edge, before any read side effect lands
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= reg_valid_i && !reg_write_i;
    end
    if (reg_valid_i && !reg_write_i) begin
      rdata_q <= rdata_mux;
    end
  end

  assign reg_rvalid_o = rvalid_q;
  assign reg_rdata_o  = rdata_q;

  // ------------------------------
  // blocks
  // ------------------------------
  plic i_plic (
    .clk_i         ( clk_i                ),
    .reset_i       ( reset_i              ),
    .sel_i         ( plic_sel             ),
    .write_i       ( reg_write_i          ),
    .offset_i      ( offset               ),
    .wdata_i       ( reg_wdata_i          ),
    .irq_sources_i ( {spi_irq, uart_irq}  ),
    .rdata_o       ( plic_rdata           ),
    .irq_o         ( irq_o                )
  );

  uart_core i_uart_core (
    .clk_i    ( clk_i       ),
    .reset_i  ( reset_i     ),
    .sel_i    ( uart_sel    ),
    .write_i  ( reg_write_i ),
    .offset_i ( offset      ),
    .wdata_i  ( reg_wdata_i ),
    .rx_i     ( rx_i        ),
    .rdata_o  ( uart_rdata  ),
    .tx_o     ( tx_o        ),
    .irq_o    ( uart_irq    )
  );

  spi_master i_spi_master (
    .clk_i      ( clk_i       ),
    .reset_i    ( reset_i     ),
    .sel_i      ( spi_sel     ),
    .write_i    ( reg_write_i ),
    .offset_i   ( offset      ),
    .wdata_i    ( reg_wdata_i ),
    .spi_miso_i ( spi_miso_i  ),
    .rdata_o    ( spi_rdata   ),
    .spi_clk_o  ( spi_clk_o   ),
    .spi_mosi_o ( spi_mosi_o  ),
    .spi_ss_o   ( spi_ss_o    ),
    .irq_o      ( spi_irq     )
  );

endmodule

// File: dv/tb_ariane_peripherals.sv
`timescale 1ns/1ps

module tb_ariane_peripherals
  import periph_pkg::*;
();

  localparam int MaxCycles = 20000;
  localparam int TxDiv     = 8;

  logic                  clk_i;
  logic                  reset_i;
  logic                  reg_valid_i;
  logic                  reg_write_i;
  periph_addr_t          reg_addr_i;
  periph_data_t          reg_wdata_i;
  logic                  reg_rvalid_o;
  periph_data_t          reg_rdata_o;
  logic [NumTargets-1:0] irq_o;
  wire                   rx_i;
  logic                  tx_o;
  logic                  spi_clk_o;
  logic                  spi_mosi_o;
  wire                   spi_miso_i;
  logic                  spi_ss_o;

  int           err_count;
  int           cycle_count;
  periph_data_t rd;
  logic [7:0]   tx_byte;
  logic [7:0]   lost_byte;
  logic [7:0]   spi_byte;

  ariane_peripherals dut0 (
    .clk_i        ( clk_i        ),
    .reset_i      ( reset_i      ),
    .reg_valid_i  ( reg_valid_i  ),
    .reg_write_i  ( reg_write_i  ),
    .reg_addr_i   ( reg_addr_i   ),
    .reg_wdata_i  ( reg_wdata_i  ),
    .reg_rvalid_o ( reg_rvalid_o ),
    .reg_rdata_o  ( reg_rdata_o  ),
    .irq_o        ( irq_o        ),
    .rx_i         ( rx_i         ),
    .tx_o         ( tx_o         ),
    .spi_clk_o    ( spi_clk_o    ),
    .spi_mosi_o   ( spi_mosi_o   ),
    .spi_miso_i   ( spi_miso_i   ),
    .spi_ss_o     ( spi_ss_o     )
  );

  // uart and spi both talk to themselves
  assign rx_i       = tx_o;
  assign spi_miso_i = spi_mosi_o;

  always #4 clk_i = !clk_i;

  always @(posedge clk_i) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count == MaxCycles) begin
      $display("timeout: run stopped after %0d cycles", MaxCycles);
      $display("Something failed");
      $finish;
    end
  end

  // ------------------------------
  // concurrent checks
  // ------------------------------
  assert property (@(posedge clk_i) reset_i |=>
    (tx_o && spi_ss_o && !spi_clk_o && (irq_o == '0) && !reg_rvalid_o))
  else begin
    err_count++;
    $display("ERR %0t: outputs not at reset values", $time);
  end

  assert property (@(posedge clk_i) disable iff (reset_i)
    (reg_valid_i && !reg_write_i) |=> reg_rvalid_o)
  else begin
    err_count++;
    $display("ERR %0t: no read valid one cycle after a read", $time);
  end

  assert property (@(posedge clk_i) disable iff (reset_i)
    reg_rvalid_o |-> $past(reg_valid_i && !reg_write_i))
  else begin
    err_count++;
    $display("ERR %0t: read valid without a read", $time);
  end

  // spi clock only toggles inside a select window
  assert property (@(posedge clk_i) disable iff (reset_i) spi_clk_o |-> !spi_ss_o)
  else begin
    err_count++;
    $display("ERR %0t: spi clock high with slave select released", $time);
  end

  // ------------------------------
  // bus and check helpers
  // ------------------------------
  function automatic periph_addr_t make_addr(input region_t region, input reg_offset_t off);
    return {region, 6'b0, off, 2'b00};
  endfunction

  task automatic expect_value(input string what, input periph_data_t got,
                              input periph_data_t exp);
    assert (got == exp) else begin
      err_count++;
      $display("ERR %0t: %s got %0h, expected %0h", $time, what, got, exp);
    end
  endtask

  task automatic write_reg(input region_t region, input reg_offset_t off,
                           input periph_data_t data);
    @(posedge clk_i);
    reg_valid_i <= 1'b1;
    reg_write_i <= 1'b1;
    reg_addr_i  <= make_addr(region, off);
    reg_wdata_i <= data;
    @(posedge clk_i);
    reg_valid_i <= 1'b0;
    reg_write_i <= 1'b0;
  endtask

  // data comes back one cycle after the access edge
  task automatic read_reg(input region_t region, input reg_offset_t off,
                          output periph_data_t data);
    @(posedge clk_i);
    reg_valid_i <= 1'b1;
    reg_write_i <= 1'b0;
    reg_addr_i  <= make_addr(region, off);
    @(posedge clk_i);
    reg_valid_i <= 1'b0;
    @(negedge clk_i);
    expect_value("read valid", 32'(reg_rvalid_o), 32'h1);
    data = reg_rdata_o;
  endtask

  task automatic poll_status(input region_t region, input reg_offset_t off,
                             input int bit_idx, input logic value);
    periph_data_t status;
    read_reg(region, off, status);
    while (status[bit_idx] != value) begin
      read_reg(region, off, status);
    end
  endtask

  // 8N1, sampled mid bit counted from the start edge
  task automatic watch_tx_frame(input logic [7:0] data, input int div);
    logic [9:0] frame;
    frame = {1'b1, data, 1'b0};
    @(negedge tx_o);
    repeat (div / 2) @(negedge clk_i);
    for (int i = 0; i < 10; i++) begin
      expect_value("uart tx bit", 32'(tx_o), 32'(frame[i]));
      repeat (div) @(negedge clk_i);
    end
  endtask

  task automatic watch_spi_byte(input logic [7:0] data);
    @(negedge spi_ss_o);
    for (int i = 7; i >= 0; i--) begin
      @(posedge spi_clk_o);
      expect_value("spi ss in transfer", 32'(spi_ss_o), 32'h0);
      expect_value("spi mosi bit", 32'(spi_mosi_o), 32'(data[i]));
    end
  endtask

  // ------------------------------
  // stimulus
  // ------------------------------
  initial begin
    clk_i       = 1'b0;
    reset_i     = 1'b1;
    reg_valid_i = 1'b0;
    reg_write_i = 1'b0;
    reg_addr_i  = '0;
    reg_wdata_i = '0;
    err_count   = 0;
    cycle_count = 0;
    void'($urandom(57685));
    repeat (2) @(posedge clk_i);
    reset_i <= 1'b0;
    @(negedge clk_i);
    expect_value("tx idle", 32'(tx_o), 32'h1);
    expect_value("spi ss idle", 32'(spi_ss_o), 32'h1);
    expect_value("irq after reset", 32'(irq_o), 32'h0);

    // readback
    write_reg(RegionPlic, OffPrio1, 32'h3);
    read_reg(RegionPlic, OffPrio1, rd);
    expect_value("prio1 readback", rd, 32'h3);
    write_reg(RegionPlic, OffThresh1, 32'h6);
    read_reg(RegionPlic, OffThresh1, rd);
    expect_value("thresh1 readback", rd, 32'h6);
    write_reg(RegionUart, OffUartDiv, 32'h2);
    read_reg(RegionUart, OffUartDiv, rd);
    expect_value("divisor clamp", rd, 32'(UartDivMin));
    write_reg(RegionUart, OffUartDiv, TxDiv);
    read_reg(RegionUart, OffUartDiv, rd);
    expect_value("divisor readback", rd, TxDiv);
    read_reg(4'hf, 4'd0, rd);
    expect_value("unused region", rd, 32'h0);

    // uart frame out and back in
    tx_byte = 8'($urandom);
    fork
      write_reg(RegionUart, OffUartData, {24'b0, tx_byte});
      watch_tx_frame(tx_byte, TxDiv);
    join
    poll_status(RegionUart, OffUartStatus, 0, 1'b0);
    read_reg(RegionUart, OffUartStatus, rd);
    expect_value("uart status after frame", rd, 32'h2);
    read_reg(RegionUart, OffUartData, rd);
    expect_value("uart rx byte", rd, {24'b0, tx_byte});
    read_reg(RegionUart, OffUartStatus, rd);
    expect_value("uart status after pop", rd, 32'h0);

    // second write lands while busy and must be dropped
    tx_byte   = 8'($urandom);
    lost_byte = ~tx_byte;
    write_reg(RegionUart, OffUartData, {24'b0, tx_byte});
    write_reg(RegionUart, OffUartData, {24'b0, lost_byte});
    poll_status(RegionUart, OffUartStatus, 0, 1'b0);
    read_reg(RegionUart, OffUartData, rd);
    expect_value("uart byte after busy write", rd, {24'b0, tx_byte});

    // spi byte through the loopback
    spi_byte = 8'($urandom);
    fork
      write_reg(RegionSpi, OffSpiData, {24'b0, spi_byte});
      watch_spi_byte(spi_byte);
    join
    poll_status(RegionSpi, OffSpiStatus, 0, 1'b0);
    read_reg(RegionSpi, OffSpiStatus, rd);
    expect_value("spi status after transfer", rd, 32'h2);
    read_reg(RegionSpi, OffSpiData, rd);
    expect_value("spi rx byte", rd, {24'b0, spi_byte});

    // ------------------------------
    // interrupts
    // ------------------------------
    write_reg(RegionUart, OffUartIrqEn, 32'h1);
    write_reg(RegionSpi, OffSpiIrqEn, 32'h1);
    write_reg(RegionPlic, OffPrio1, 32'h2);
    write_reg(RegionPlic, OffPrio2, 32'h5);
    write_reg(RegionPlic, OffEnable0, 32'h3);
    write_reg(RegionPlic, OffThresh0, 32'h1);
    write_reg(RegionPlic, OffEnable1, 32'h1);
    write_reg(RegionPlic, OffThresh1, 32'h3);
    write_reg(RegionUart, OffUartData, 32'($urandom) & 32'hff);
    write_reg(RegionSpi, OffSpiData, 32'($urandom) & 32'hff);
    poll_status(RegionUart, OffUartStatus, 1, 1'b1);
    poll_status(RegionSpi, OffSpiStatus, 1, 1'b1);
    @(negedge clk_i);
    expect_value("irq both pending", 32'(irq_o), 32'h1);

    read_reg(RegionPlic, OffClaim0, rd);
    expect_value("first claim", rd, 32'(SrcSpi));
    write_reg(RegionPlic, OffClaim0, 32'(SrcSpi));
    read_reg(RegionSpi, OffSpiData, rd);
    read_reg(RegionPlic, OffClaim0, rd);
    expect_value("second claim", rd, 32'(SrcUart));
    write_reg(RegionPlic, OffClaim0, 32'(SrcUart));

    // target 1 now sees the uart level
    write_reg(RegionPlic, OffThresh1, 32'h1);
    @(negedge clk_i);
    expect_value("irq with low thresh1", 32'(irq_o), 32'h3);
    read_reg(RegionUart, OffUartData, rd);
    @(negedge clk_i);
    expect_value("irq after uart pop", 32'(irq_o), 32'h0);

    repeat (4) @(posedge clk_i);
    $display("checks failed: %0d", err_count);
    if (err_count == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

// File: ariane_peripherals.f
hdl/periph_pkg.sv
hdl/plic.sv
hdl/uart_core.sv
hdl/spi_master.sv
hdl/ariane_peripherals.sv
dv/tb_ariane_peripherals.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build the peripheral testbench with verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_ariane_peripherals \
  -f ariane_peripherals.f
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

sim_out=$(./obj_dir/Vtb_ariane_peripherals)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi

if grep -qx "Everything OK" <<< "$sim_out"; then
  exit 0
fi
exit 1
